/* apb_subsystem.f */
+incdir+source
source/apb_sys_pkg.sv
source/apb_if.sv
source/wb_apb_bridge.sv
source/apb_delayer.sv
source/apb_decoder.sv
source/apb_reg_bank.sv
source/apb_word_ram.sv
source/apb_subsystem.sv
tb/apb_subsystem_tb.sv

/* Bender.yml */
package:
  name: apb_subsystem

export_include_dirs:
  - source

sources:
  - source/apb_sys_pkg.sv
  - source/apb_if.sv
  - source/wb_apb_bridge.sv
  - source/apb_delayer.sv
  - source/apb_decoder.sv
  - source/apb_reg_bank.sv
  - source/apb_word_ram.sv
  - source/apb_subsystem.sv
  - target: test
    files:
      - tb/apb_subsystem_tb.sv

/* tb/apb_subsystem_tb.sv */
`timescale 1ns/10ps
`include "apb_sys_macros.svh"

module apb_subsystem_tb;

    localparam int fast_cycles = 3;  // Setup, one access cycle, then the ack cycle.
    localparam int ram_n = 2;
    localparam int slow_cycles = 1 + ram_n + ((ram_n * `DELAY_NUM) >> `DELAY_DEN_LOG2) + 2;
    localparam int total_xfers = 7 + 19 + 2 + 40 + 4 + 24;
    localparam int xfer_cycles = slow_cycles + 3;  // Worst case plus handshake overhead.
    localparam int timeout_cycles = 2 * (5 + total_xfers * xfer_cycles);

    logic clock = 1'b0;
    logic reset;
    logic wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
    logic [`ADDR_W-1:0] wb_adr;
    logic [`DATA_W-1:0] wb_dat_w, wb_dat_r;
    logic [`STRB_W-1:0] wb_sel;

    logic [31:0] shadow_reg [7];
    logic [31:0] shadow_ram [64];
    logic [15:0] lfsr_q;
    logic        exp_we, exp_err;
    logic [31:0] exp_data;
    int          exp_cycles, cyc_count;
    int          errors, errors_at_start, tests_run, tests_failed;

    apb_subsystem uut (.*);

    always #5 clock = ~clock;

    // Counts rising edges since the request was raised.
    always @(posedge clock) cyc_count <= wb_stb ? cyc_count + 1 : 0;

    a_ack_err_exclusive: assert property (@(posedge clock) !(wb_ack && wb_err))
        else begin
            $display("ERROR %0t: wb_ack and wb_err high together", $time);
            errors++;
        end
    a_quiet_when_idle: assert property (@(posedge clock) reset || !wb_cyc |-> !wb_ack && !wb_err)
        else begin
            $display("ERROR %0t: response without an active cycle", $time);
            errors++;
        end
    a_response_kind: assert property (@(posedge clock) disable iff (reset)
        wb_ack || wb_err |-> wb_err == exp_err)
        else begin
            $display("ERROR %0t: got err=%0b, expected %0b", $time, wb_err, exp_err);
            errors++;
        end
    a_latency: assert property (@(posedge clock) disable iff (reset)
        wb_ack || wb_err |-> cyc_count == exp_cycles)
        else begin
            $display("ERROR %0t: completed in cycle %0d, expected %0d", $time,
                     cyc_count, exp_cycles);
            errors++;
        end
    a_read_data: assert property (@(posedge clock) disable iff (reset)
        wb_ack && !exp_we |-> wb_dat_r == exp_data)
        else begin
            $display("ERROR %0t: read %h, expected %h", $time, wb_dat_r, exp_data);
            errors++;
        end

    // Fibonacci LFSR with taps 16, 14, 13, 11; one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] sel);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    task automatic run_transfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                                input logic [3:0] sel, input logic [31:0] expd,
                                input logic experr, input int expcyc);
        int waited;
        @(negedge clock);
        exp_we = we;
        exp_data = expd;
        exp_err = experr;
        exp_cycles = expcyc;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w, wb_sel} = {2'b11, we, adr, dat, sel};
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!(wb_ack || wb_err) && waited < 4 * slow_cycles);
        if (!(wb_ack || wb_err)) begin
            $display("No response to the transfer at address %h, giving up on it.", adr);
            errors++;
        end
        @(negedge clock);
        {wb_cyc, wb_stb, wb_we} = 3'b000;  // Held through the edge that sees the ack.
    endtask

    task automatic write_reg(input int idx, input logic [31:0] data, input logic [3:0] sel);
        if (idx < 7) shadow_reg[idx] = merge_bytes(shadow_reg[idx], data, sel);
        run_transfer(1'b1, {`REG_WIN, 23'h0, idx[2:0], 2'b00}, data, sel, '0, 1'b0, fast_cycles);
    endtask

    task automatic read_reg(input int idx);
        logic [31:0] expd;
        if (idx == 7) expd = `REG_ID;
        else expd = shadow_reg[idx];
        run_transfer(1'b0, {`REG_WIN, 23'h0, idx[2:0], 2'b00}, '0, 4'hF, expd, 1'b0, fast_cycles);
    endtask

    task automatic write_ram(input int idx, input logic [31:0] data, input logic [3:0] sel);
        shadow_ram[idx] = merge_bytes(shadow_ram[idx], data, sel);
        run_transfer(1'b1, {`RAM_WIN, 20'h0, idx[5:0], 2'b00}, data, sel, '0, 1'b0, slow_cycles);
    endtask

    task automatic read_ram(input int idx);
        run_transfer(1'b0, {`RAM_WIN, 20'h0, idx[5:0], 2'b00}, '0, 4'hF, shadow_ram[idx], 1'b0,
                     slow_cycles);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) $display("Test %s: ok", name);
        else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        int idx;
        lfsr_q = 16'd7334;
        {errors, errors_at_start, tests_run, tests_failed} = '0;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w, wb_sel} = '0;
        {exp_we, exp_err, exp_data, exp_cycles} = '0;
        for (int i = 0; i < 7; i++) shadow_reg[i] = '0;
        reset = 1'b1;
        repeat (5) @(negedge clock);
        reset = 1'b0;

        for (int i = 0; i < 7; i++) read_reg(i);
        end_test("reset");

        repeat (12) begin
            idx = rand_bits(3) % 7;
            write_reg(idx, rand_bits(32), rand_bits(4));
        end
        for (int i = 0; i < 7; i++) read_reg(i);
        end_test("register bank");

        write_reg(7, rand_bits(32), 4'hF);
        read_reg(7);
        end_test("id register");

        for (int i = 0; i < 16; i++) write_ram(i, rand_bits(32), 4'hF);
        repeat (8) begin
            idx = rand_bits(4);
            write_ram(idx, rand_bits(32), rand_bits(4));
        end
        for (int i = 0; i < 16; i++) read_ram(i);
        end_test("ram through delayer");

        // Bits 7:2 of this address would hit register 2 and RAM word 2 if it leaked.
        run_transfer(1'b1, 32'h5000_0008, rand_bits(32), 4'hF, '0, 1'b1, fast_cycles);
        run_transfer(1'b0, 32'h5000_0008, '0, 4'hF, '0, 1'b1, fast_cycles);
        read_reg(2);
        read_ram(2);
        end_test("unmapped address");

        repeat (6) begin
            idx = rand_bits(3) % 7;
            write_reg(idx, rand_bits(32), rand_bits(4));
            read_ram(rand_bits(4));
            read_reg(idx);
            idx = rand_bits(4);
            write_ram(idx, rand_bits(32), rand_bits(4));
        end
        end_test("interleaving");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * 10);
        $display("Timeout: the tests did not finish within %0d clock cycles.", timeout_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* source/apb_subsystem.sv */
`timescale 1ns/10ps
`include "apb_sys_macros.svh"

module apb_subsystem (
    input  logic               clock,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [`ADDR_W-1:0] wb_adr,
    input  logic [`DATA_W-1:0] wb_dat_w,
    input  logic [`STRB_W-1:0] wb_sel,
    output logic [`DATA_W-1:0] wb_dat_r,
    output logic               wb_ack,
    output logic               wb_err
);

    apb_if bus_up ();
    apb_if bus_mid ();
    apb_if bus_reg ();
    apb_if bus_ram ();

    wb_apb_bridge u_bridge (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .apb      (bus_up)
    );

    apb_delayer u_delayer (
        .clock (clock),
        .reset (reset),
        .up    (bus_up),
        .down  (bus_mid)
    );

    apb_decoder u_decoder (
        .clock   (clock),
        .reset   (reset),
        .up      (bus_mid),
        .reg_bus (bus_reg),
        .ram_bus (bus_ram)
    );

    apb_reg_bank u_reg_bank (
        .clock (clock),
        .reset (reset),
        .bus   (bus_reg)
    );

    apb_word_ram u_word_ram (
        .clock (clock),
        .reset (reset),
        .bus   (bus_ram)
    );

endmodule

/* source/apb_word_ram.sv */
`timescale 1ns/10ps
`include "apb_sys_macros.svh"

module apb_word_ram (
    input  logic clock,
    input  logic reset,
    apb_if.slave bus
);

    logic [`DATA_W-1:0] mem [64];
    logic [5:0]         idx;
    logic               access;
    logic               wait_q;

    assign idx    = bus.paddr[7:2];
    assign access = bus.psel && bus.penable;

    // High during the second access cycle only, low again after completion.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) wait_q <= 1'b0;
        else       wait_q <= access && !wait_q;
    end

    always_ff @(posedge clock) begin
        if (access && wait_q && bus.pwrite) begin
            for (int b = 0; b < `STRB_W; b++) begin
                if (bus.pstrb[b]) mem[idx][8*b +: 8] <= bus.pwdata[8*b +: 8];
            end
        end
    end

    assign bus.prdata  = mem[idx];
    assign bus.pready  = wait_q;
    assign bus.pslverr = 1'b0;

endmodule

/* source/apb_reg_bank.sv */
`timescale 1ns/10ps
`include "apb_sys_macros.svh"

module apb_reg_bank (
    input  logic clock,
    input  logic reset,
    apb_if.slave bus
);

    logic [`DATA_W-1:0] regs [7];  // Register 7 is the ID constant and has no storage.
    logic [2:0]         idx;
    logic               wr_en;

    assign idx   = bus.paddr[4:2];
    assign wr_en = bus.psel && bus.penable && bus.pwrite && (idx != 3'd7);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 7; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < `STRB_W; b++) begin
                if (bus.pstrb[b]) regs[idx][8*b +: 8] <= bus.pwdata[8*b +: 8];
            end
        end
    end

    assign bus.prdata  = (idx == 3'd7) ? `REG_ID : regs[idx];
    assign bus.pready  = 1'b1;  // No wait states.
    assign bus.pslverr = 1'b0;

endmodule

/* source/apb_decoder.sv */
`timescale 1ns/10ps
`include "apb_sys_macros.svh"

module apb_decoder (
    input  logic  clock,
    input  logic  reset,
    apb_if.slave  up,
    apb_if.master reg_bus,
    apb_if.master ram_bus
);
    import apb_sys_pkg::*;

    periph_sel_t sel;

    always_comb begin
        case (up.paddr[31:28])
            `REG_WIN: sel = SEL_REG;
            `RAM_WIN: sel = SEL_RAM;
            default:  sel = SEL_NONE;
        endcase
    end

    assign reg_bus.paddr   = up.paddr;
    assign reg_bus.penable = up.penable;
    assign reg_bus.pwrite  = up.pwrite;
    assign reg_bus.pwdata  = up.pwdata;
    assign reg_bus.pstrb   = up.pstrb;
    assign reg_bus.psel    = up.psel && (sel == SEL_REG);

    assign ram_bus.paddr   = up.paddr;
    assign ram_bus.penable = up.penable;
    assign ram_bus.pwrite  = up.pwrite;
    assign ram_bus.pwdata  = up.pwdata;
    assign ram_bus.pstrb   = up.pstrb;
    assign ram_bus.psel    = up.psel && (sel == SEL_RAM);

    always_comb begin
        case (sel)
            SEL_REG: begin
                up.pready  = reg_bus.pready;
                up.prdata  = reg_bus.prdata;
                up.pslverr = reg_bus.pslverr;
            end
            SEL_RAM: begin
                up.pready  = ram_bus.pready;
                up.prdata  = ram_bus.prdata;
                up.pslverr = ram_bus.pslverr;
            end
            default: begin
                up.pready  = 1'b1;  // Unmapped, so error out in the first access cycle.
                up.prdata  = '0;
                up.pslverr = 1'b1;
            end
        endcase
    end

    a_target_onehot: assert property (@(posedge clock) disable iff (reset)
        up.psel && up.penable |-> $onehot0({reg_bus.psel, ram_bus.psel}) && sel == $past(sel));

endmodule

/* source/apb_delayer.sv */
`timescale 1ns/10ps
`include "apb_sys_macros.svh"

module apb_delayer (
    input  logic  clock,
    input  logic  reset,
    apb_if.slave  up,
    apb_if.master down
);
    import apb_sys_pkg::*;

    localparam int cnt_w  = 8;
    localparam int prod_w = 2 * cnt_w;

    delay_state_t       state;
    logic [cnt_w-1:0]   n_cnt;
    logic [cnt_w-1:0]   wait_cnt;
    logic [prod_w-1:0]  scaled;
    logic [`DATA_W-1:0] prdata_q;
    logic               pslverr_q;
    logic               slow_hit;
    logic               down_done;

    assign slow_hit  = (up.paddr[31:28] >= `SLOW_LO) && (up.paddr[31:28] < `SLOW_HI);
    assign down_done = down.psel && down.penable && down.pready;
    // Access cycles so far, including the one completing now, scaled by the ratio.
    assign scaled = prod_w'(n_cnt + 1'b1) * prod_w'(`DELAY_NUM);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= DL_IDLE;
            n_cnt    <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                DL_IDLE: begin
                    if (up.psel && slow_hit) begin
                        state <= DL_REQ;
                        n_cnt <= '0;
                    end
                end
                DL_REQ: begin
                    if (down.psel && down.penable) n_cnt <= n_cnt + 1'b1;
                    if (down_done) begin
                        state    <= DL_WAIT;
                        wait_cnt <= cnt_w'(scaled >> `DELAY_DEN_LOG2);
                    end
                end
                DL_WAIT: begin
                    if (wait_cnt == '0) state <= DL_IDLE;
                    else wait_cnt <= wait_cnt - 1'b1;
                end
                default: state <= DL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == DL_REQ && down_done) begin
            prdata_q  <= down.prdata;
            pslverr_q <= down.pslverr;
        end
    end

    assign down.paddr   = up.paddr;
    assign down.pwrite  = up.pwrite;
    assign down.pwdata  = up.pwdata;
    assign down.pstrb   = up.pstrb;
    assign down.psel    = up.psel && (state != DL_WAIT);
    assign down.penable = up.penable && (state != DL_WAIT);

    always_comb begin
        case (state)
            DL_IDLE: begin
                up.pready  = down.pready;
                up.prdata  = down.prdata;
                up.pslverr = down.pslverr;
            end
            DL_WAIT: begin
                up.pready  = (wait_cnt == '0);  // One cycle at the end of the stretch.
                up.prdata  = prdata_q;
                up.pslverr = pslverr_q;
            end
            default: begin
                up.pready  = 1'b0;
                up.prdata  = prdata_q;
                up.pslverr = pslverr_q;
            end
        endcase
    end

    // The master keeps its access up while the peripheral sits deselected.
    a_wait_deselected: assert property (@(posedge clock) disable iff (reset)
        state == DL_WAIT |-> up.psel && up.penable && !down.psel);

endmodule

/* source/wb_apb_bridge.sv */
`timescale 1ns/10ps
`include "apb_sys_macros.svh"

module wb_apb_bridge (
    input  logic               clock,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [`ADDR_W-1:0] wb_adr,
    input  logic [`DATA_W-1:0] wb_dat_w,
    input  logic [`STRB_W-1:0] wb_sel,
    output logic [`DATA_W-1:0] wb_dat_r,
    output logic               wb_ack,
    output logic               wb_err,
    apb_if.master              apb
);
    import apb_sys_pkg::*;

    bridge_state_t      state;
    logic               err_q;
    logic [`ADDR_W-1:0] paddr_q;
    logic               pwrite_q;
    logic [`DATA_W-1:0] pwdata_q;
    logic [`STRB_W-1:0] pstrb_q;
    logic [`DATA_W-1:0] dat_r_q;
    logic               wb_req;
    logic               apb_done;

    assign wb_req   = wb_cyc && wb_stb;
    assign apb_done = (state == BR_ACCESS) && apb.pready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= BR_IDLE;
            err_q <= 1'b0;
        end else begin
            case (state)
                BR_IDLE:   if (wb_req) state <= BR_SETUP;
                BR_SETUP:  state <= BR_ACCESS;
                BR_ACCESS: begin
                    if (apb.pready) begin
                        state <= BR_ACK;
                        err_q <= apb.pslverr;  // Decides between ack and err.
                    end
                end
                BR_ACK:    state <= BR_IDLE;
                default:   state <= BR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == BR_IDLE && wb_req) begin
            paddr_q  <= wb_adr;
            pwrite_q <= wb_we;
            pwdata_q <= wb_dat_w;
            pstrb_q  <= wb_we ? wb_sel : '0;  // APB wants zero strobes on reads.
        end
        if (apb_done && !pwrite_q) dat_r_q <= apb.prdata;
    end

    assign apb.paddr   = paddr_q;
    assign apb.pwrite  = pwrite_q;
    assign apb.pwdata  = pwdata_q;
    assign apb.pstrb   = pstrb_q;
    assign apb.psel    = (state == BR_SETUP) || (state == BR_ACCESS);
    assign apb.penable = (state == BR_ACCESS);

    assign wb_dat_r = dat_r_q;
    assign wb_ack   = (state == BR_ACK) && !err_q;
    assign wb_err   = (state == BR_ACK) && err_q;

    // An access phase always follows a setup phase of the same transfer.
    a_penable_after_psel: assert property (@(posedge clock) disable iff (reset)
        apb.penable |-> apb.psel && $past(apb.psel));

    a_request_stable: assert property (@(posedge clock) disable iff (reset)
        apb.psel && apb.penable && !apb.pready |=>
            $stable({apb.paddr, apb.pwrite, apb.pwdata, apb.pstrb}));

endmodule

/* source/apb_if.sv */
`timescale 1ns/10ps
`include "apb_sys_macros.svh"

interface apb_if;

    logic [`ADDR_W-1:0] paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`DATA_W-1:0] pwdata;
    logic [`STRB_W-1:0] pstrb;
    logic               pready;
    logic [`DATA_W-1:0] prdata;
    logic               pslverr;

    modport master (
        output paddr, psel, penable, pwrite, pwdata, pstrb,
        input  pready, prdata, pslverr
    );

    modport slave (
        input  paddr, psel, penable, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );

endinterface

/* source/apb_sys_pkg.sv */
package apb_sys_pkg;

    typedef enum logic [1:0] {
        BR_IDLE   = 2'd0,
        BR_SETUP  = 2'd1,
        BR_ACCESS = 2'd2,
        BR_ACK    = 2'd3
    } bridge_state_t;

    typedef enum logic [1:0] {
        DL_IDLE = 2'd0,  // Transfers pass straight through.
        DL_REQ  = 2'd1,  // Counting access cycles of a slow transfer.
        DL_WAIT = 2'd2   // Stretching with the downstream side deselected.
    } delay_state_t;

    typedef enum logic [1:0] {
        SEL_REG  = 2'd0,
        SEL_RAM  = 2'd1,
        SEL_NONE = 2'd2
    } periph_sel_t;

endpackage

/* source/apb_sys_macros.svh */
`ifndef APB_SYS_MACROS_SVH
`define APB_SYS_MACROS_SVH

`define ADDR_W 32
`define DATA_W 32
`define STRB_W (`DATA_W / 8)

// Address windows are matched on paddr[31:28].
`define REG_WIN 4'h0
`define RAM_WIN 4'hA
`define SLOW_LO 4'hA
`define SLOW_HI 4'hC

`define DELAY_NUM      5  // Slow clock period is 5/2 of the main one.
`define DELAY_DEN_LOG2 1

`define REG_ID 32'h4150_4231

`endif
